//--- compile.f
logic/conv_cfg_pkg.sv
logic/conv_ctrl_pkg.sv
logic/tile_if.sv
logic/tile_sequencer.sv
logic/scan_walker.sv
logic/row_lane.sv
logic/conv_router.sv
bench/conv_router_properties.sv
bench/conv_router_tb.sv

//--- Makefile
TOP := conv_router_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f compile.f -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee /dev/stderr | grep -qx "TEST OK"

clean:
	rm -rf obj_dir

//--- bench/conv_router_tb.sv
module conv_router_tb;

  localparam int TILE_W   = conv_cfg_pkg::PIXELS_PER_ROW;
  localparam int TILE_H   = conv_cfg_pkg::ROW_LANES;
  localparam int NO_ROW_I = 32'h0000_ffff;

  // one column per run in test order
  localparam int N_RUNS = 4;
  localparam int CFG_OX  [N_RUNS] = '{20, 32, 12, 70};
  localparam int CFG_OY  [N_RUNS] = '{3, 3, 4, 7};
  localparam int CFG_IX  [N_RUNS] = '{22, 34, 12, 70};
  localparam int CFG_IY  [N_RUNS] = '{5, 5, 4, 7};
  localparam int CFG_NIF [N_RUNS] = '{2, 4, 2, 2};
  localparam int CFG_K   [N_RUNS] = '{3, 3, 3, 3};
  localparam int CFG_P   [N_RUNS] = '{0, 0, 1, 1};
  localparam int CFG_NL  [N_RUNS] = '{1, 2, 1, 2};
  localparam int CFG_IL  [N_RUNS] = '{5, 6, 4, 7};

  logic clk = 1'b0;
  logic reset;
  logic start;
  logic conv_out_add_end;
  conv_cfg_pkg::dim_t ox, oy, ix, iy, nif;
  conv_cfg_pkg::small_t k, p, nif_log2, ix_log2;
  logic busy;
  conv_cfg_pkg::dim_t ox_start, oy_start, pox, poy, if_idx;
  conv_cfg_pkg::dim_t cur_ox_start, cur_oy_start, cur_pox, cur_poy;
  conv_cfg_pkg::dim_t row1_idx, row2_idx, row3_idx;
  conv_cfg_pkg::bank_t row1_buf_idx, row2_buf_idx, row3_buf_idx;
  conv_cfg_pkg::dim_t row1_buf_adr, row2_buf_adr, row3_buf_adr;
  logic valid_row1_adr, valid_row2_adr, valid_row3_adr;
  logic conv_pixels_add_end, conv_nif_add_end, conv_end;

  // model state advanced by the monitor
  int cfg_iy, cfg_nif, cfg_k, cfg_p, cfg_nl, cfg_il;
  int tile_ox[$], tile_oy[$], tile_pox[$], tile_poy[$];
  int px, kr, ch, ti;
  bit in_hold, cur_due;
  int valid_cnt, pass_cnt, nif_cnt, end_cnt, both_cnt, gap_cnt, hold_cnt, max_ch;
  int errors = 0;
  int tests = 0;
  int failed_tests = 0;
  integer seed = 32'h31e9;

  always #20 clk = ~clk;

  conv_router #(.PIXELS_PER_ROW(TILE_W)) dut0 (.*);

  bind conv_router conv_router_properties props0 (
    .clk(clk), .reset(reset), .busy(busy), .state(tile_bus.state),
    .valid_row1_adr(valid_row1_adr), .valid_row2_adr(valid_row2_adr),
    .valid_row3_adr(valid_row3_adr), .row1_buf_idx(row1_buf_idx),
    .row2_buf_idx(row2_buf_idx), .row3_buf_idx(row3_buf_idx),
    .conv_nif_add_end(conv_nif_add_end), .conv_end(conv_end)
  );

  ////////////////////////////////////////////////////////////
  // reporting
  ////////////////////////////////////////////////////////////

  task automatic report_value(input string name, input int exp_v, input int act_v);
    $display("FAILED at %0t: %s expected %0h actual %0h", $time, name, exp_v, act_v);
    errors++;
  endtask

  task automatic report_error(input string what);
    $display("error at %0t: %s", $time, what);
    errors++;
  endtask

  task automatic report_test(input string name, input int err0);
    tests++;
    if (errors == err0)
    begin
      $display("%s: pass", name);
    end
    else
    begin
      $display("%s: %0d errors", name, errors - err0);
      failed_tests++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////

  // cycles for one run with a hold allowance per tile
  function automatic int run_budget(input int r);
    int sum;
    int w;
    sum = 0;
    for (int y = 0; y < CFG_OY[r]; y += TILE_H)
    begin
      for (int x = 0; x < CFG_OX[r]; x += TILE_W)
      begin
        w = (CFG_OX[r] - x < TILE_W) ? CFG_OX[r] - x : TILE_W;
        sum += CFG_NIF[r] * CFG_K[r] * (w + CFG_K[r] - 1) + 16;
      end
    end
    return sum;
  endfunction

  task automatic check_cur(input int idx);
    if (int'(cur_ox_start) != tile_ox[idx]) report_value("cur_ox_start", tile_ox[idx],
                                                         int'(cur_ox_start));
    if (int'(cur_oy_start) != tile_oy[idx]) report_value("cur_oy_start", tile_oy[idx],
                                                         int'(cur_oy_start));
    if (int'(cur_pox) != tile_pox[idx]) report_value("cur_pox", tile_pox[idx], int'(cur_pox));
    if (int'(cur_poy) != tile_poy[idx]) report_value("cur_poy", tile_poy[idx], int'(cur_poy));
  endtask

  // expected lane output from tile, kernel row and channel
  task automatic check_lane(input int lane, input int act_row, input int act_bank,
                            input int act_adr, input bit act_valid);
    int row;
    int exp_row;
    int exp_bank;
    int exp_adr;
    bit present;
    row = tile_oy[ti] + lane + kr - cfg_p;
    present = (lane < tile_poy[ti]) && (row >= 0) && (row < cfg_iy);
    exp_row = NO_ROW_I;
    exp_bank = 0;
    exp_adr = NO_ROW_I;
    if (present)
    begin
      exp_row = row;
      exp_bank = row % 3 + 1;
      // row group, tile column words, channel word
      exp_adr = ((row / 3) << (cfg_nl + cfg_il - 5)) + ((tile_ox[ti] << cfg_nl) >> 5)
                + ch - 1;
      exp_adr = exp_adr & 32'h0000_ffff;
    end
    if (act_row != exp_row) report_value($sformatf("row%0d_idx", lane + 1), exp_row, act_row);
    if (act_bank != exp_bank) report_value($sformatf("row%0d_buf_idx", lane + 1), exp_bank,
                                           act_bank);
    if (act_adr != exp_adr) report_value($sformatf("row%0d_buf_adr", lane + 1), exp_adr,
                                         act_adr);
    if (act_valid != present) report_value($sformatf("valid_row%0d_adr", lane + 1),
                                           int'(present), int'(act_valid));
  endtask

  // samples at the rising edge while inputs move on the falling one
  always @(posedge clk)
  begin : monitor
    bit pass_exp;
    bit nif_exp;
    bit end_exp;
    if (!reset && (!busy || in_hold))
    begin
      if (valid_row1_adr || valid_row2_adr || valid_row3_adr)
        report_error("row address valid while not scanning");
      if (in_hold)
      begin
        hold_cnt++;
        // previous tile stays on cur_* until release
        check_cur(ti - 1);
        if (conv_out_add_end)
        begin
          in_hold = 1'b0;
          cur_due = 1'b1;
        end
      end
    end
    else if (!reset)
    begin
      if (cur_due)
        check_cur(ti);
      cur_due = 1'b0;
      if (int'(ox_start) != tile_ox[ti]) report_value("ox_start", tile_ox[ti], int'(ox_start));
      if (int'(oy_start) != tile_oy[ti]) report_value("oy_start", tile_oy[ti], int'(oy_start));
      if (int'(pox) != tile_pox[ti]) report_value("pox", tile_pox[ti], int'(pox));
      if (int'(poy) != tile_poy[ti]) report_value("poy", tile_poy[ti], int'(poy));
      if (int'(if_idx) != ch) report_value("if_idx", ch, int'(if_idx));
      check_lane(0, int'(row1_idx), int'(row1_buf_idx), int'(row1_buf_adr), valid_row1_adr);
      check_lane(1, int'(row2_idx), int'(row2_buf_idx), int'(row2_buf_adr), valid_row2_adr);
      check_lane(2, int'(row3_idx), int'(row3_buf_idx), int'(row3_buf_adr), valid_row3_adr);
      // pulses expected from the model position
      pass_exp = px == tile_pox[ti] + cfg_k - 2;
      nif_exp = pass_exp && (kr == cfg_k - 1) && (ch == cfg_nif);
      end_exp = nif_exp && (ti == tile_ox.size() - 1);
      if (conv_pixels_add_end != pass_exp) report_value("conv_pixels_add_end", int'(pass_exp),
                                                        int'(conv_pixels_add_end));
      if (conv_nif_add_end != nif_exp) report_value("conv_nif_add_end", int'(nif_exp),
                                                    int'(conv_nif_add_end));
      if (conv_end != end_exp) report_value("conv_end", int'(end_exp), int'(conv_end));
      if (valid_row1_adr) valid_cnt++;
      if (!(valid_row1_adr && valid_row2_adr && valid_row3_adr)) gap_cnt++;
      if (conv_pixels_add_end) pass_cnt++;
      if (conv_nif_add_end) nif_cnt++;
      if (conv_end) end_cnt++;
      if (conv_end && conv_nif_add_end) both_cnt++;
      if (int'(if_idx) > max_ch) max_ch = int'(if_idx);
      // step pixel, kernel row, channel, tile
      if (pass_exp && kr == cfg_k - 1 && ch == cfg_nif)
      begin
        px = 0;
        kr = 0;
        ch = 1;
        ti++;
        in_hold = !end_exp;
      end
      else if (pass_exp && kr == cfg_k - 1)
      begin
        px = 0;
        kr = 0;
        ch++;
      end
      else if (pass_exp)
      begin
        px = 0;
        kr++;
      end
      else
        px++;
    end
  end

  ////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////

  // one full convolution with a random release after each tile
  task automatic run_conv(input int r);
    int delay;
    ox = conv_cfg_pkg::dim_t'(CFG_OX[r]);
    oy = conv_cfg_pkg::dim_t'(CFG_OY[r]);
    ix = conv_cfg_pkg::dim_t'(CFG_IX[r]);
    iy = conv_cfg_pkg::dim_t'(CFG_IY[r]);
    nif = conv_cfg_pkg::dim_t'(CFG_NIF[r]);
    k = conv_cfg_pkg::small_t'(CFG_K[r]);
    p = conv_cfg_pkg::small_t'(CFG_P[r]);
    nif_log2 = conv_cfg_pkg::small_t'(CFG_NL[r]);
    ix_log2 = conv_cfg_pkg::small_t'(CFG_IL[r]);
    cfg_iy = CFG_IY[r];
    cfg_nif = CFG_NIF[r];
    cfg_k = CFG_K[r];
    cfg_p = CFG_P[r];
    cfg_nl = CFG_NL[r];
    cfg_il = CFG_IL[r];
    tile_ox.delete();
    tile_oy.delete();
    tile_pox.delete();
    tile_poy.delete();
    // ox inner and oy outer
    for (int y = 0; y < CFG_OY[r]; y += TILE_H)
    begin
      for (int x = 0; x < CFG_OX[r]; x += TILE_W)
      begin
        tile_ox.push_back(x);
        tile_oy.push_back(y);
        tile_pox.push_back((CFG_OX[r] - x < TILE_W) ? CFG_OX[r] - x : TILE_W);
        tile_poy.push_back((CFG_OY[r] - y < TILE_H) ? CFG_OY[r] - y : TILE_H);
      end
    end
    px = 0;
    kr = 0;
    ch = 1;
    ti = 0;
    in_hold = 1'b0;
    cur_due = 1'b0;
    valid_cnt = 0;
    pass_cnt = 0;
    nif_cnt = 0;
    end_cnt = 0;
    both_cnt = 0;
    gap_cnt = 0;
    hold_cnt = 0;
    max_ch = 0;
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    while (end_cnt == 0)
    begin
      @(negedge clk);
      if (in_hold)
      begin
        delay = {$random(seed)} % 16;
        repeat (delay) @(negedge clk);
        conv_out_add_end = 1'b1;
        @(negedge clk);
        conv_out_add_end = 1'b0;
      end
    end
    @(negedge clk);
    if (busy != 1'b0) report_value("busy", 0, int'(busy));
  endtask

  ////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////

  task automatic test_reset_state();
    int err0;
    err0 = errors;
    if (busy != 1'b0) report_value("busy", 0, int'(busy));
    if (valid_row1_adr != 1'b0) report_value("valid_row1_adr", 0, int'(valid_row1_adr));
    if (valid_row2_adr != 1'b0) report_value("valid_row2_adr", 0, int'(valid_row2_adr));
    if (valid_row3_adr != 1'b0) report_value("valid_row3_adr", 0, int'(valid_row3_adr));
    if (conv_pixels_add_end != 1'b0) report_value("conv_pixels_add_end", 0,
                                                  int'(conv_pixels_add_end));
    if (conv_nif_add_end != 1'b0) report_value("conv_nif_add_end", 0, int'(conv_nif_add_end));
    if (conv_end != 1'b0) report_value("conv_end", 0, int'(conv_end));
    if (int'(row1_buf_adr) != NO_ROW_I) report_value("row1_buf_adr", NO_ROW_I,
                                                     int'(row1_buf_adr));
    if (int'(row2_buf_adr) != NO_ROW_I) report_value("row2_buf_adr", NO_ROW_I,
                                                     int'(row2_buf_adr));
    if (int'(row3_buf_adr) != NO_ROW_I) report_value("row3_buf_adr", NO_ROW_I,
                                                     int'(row3_buf_adr));
    report_test("reset state", err0);
  endtask

  task automatic test_single_tile();
    int err0;
    int exp_valid;
    err0 = errors;
    run_conv(0);
    exp_valid = CFG_NIF[0] * CFG_K[0] * (CFG_OX[0] + CFG_K[0] - 1);
    if (valid_cnt != exp_valid) report_value("valid cycles", exp_valid, valid_cnt);
    if (pass_cnt != CFG_NIF[0] * CFG_K[0]) report_value("pixel passes", CFG_NIF[0] * CFG_K[0],
                                                        pass_cnt);
    if (nif_cnt != 1) report_value("conv_nif_add_end pulses", 1, nif_cnt);
    if (both_cnt != 1) report_value("conv_end with conv_nif_add_end", 1, both_cnt);
    report_test("single tile", err0);
  endtask

  // lane checks run in the monitor across all channels
  task automatic test_lane_map();
    int err0;
    err0 = errors;
    run_conv(1);
    if (max_ch != CFG_NIF[1]) report_value("highest if_idx", CFG_NIF[1], max_ch);
    report_test("lane mapping", err0);
  endtask

  task automatic test_padding();
    int err0;
    err0 = errors;
    run_conv(2);
    if (gap_cnt == 0) report_error("no padded or absent lane was seen");
    if (nif_cnt != 2) report_value("conv_nif_add_end pulses", 2, nif_cnt);
    report_test("padding", err0);
  endtask

  task automatic test_multi_tile();
    int err0;
    err0 = errors;
    run_conv(3);
    if (nif_cnt != tile_ox.size()) report_value("tiles done", tile_ox.size(), nif_cnt);
    if (end_cnt != 1) report_value("conv_end pulses", 1, end_cnt);
    if (hold_cnt == 0) report_error("no hold between tiles");
    report_test("multi tile", err0);
  endtask

  ////////////////////////////////////////////////////////////
  // main and watchdog
  ////////////////////////////////////////////////////////////

  initial
  begin
    reset = 1'b1;
    start = 1'b0;
    conv_out_add_end = 1'b0;
    ox = '0;
    oy = '0;
    ix = '0;
    iy = '0;
    nif = '0;
    k = '0;
    p = '0;
    nif_log2 = '0;
    ix_log2 = '0;
    repeat (8) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    test_reset_state();
    test_single_tile();
    test_lane_map();
    test_padding();
    test_multi_tile();
    $display("summary: %0d tests, %0d failing, %0d errors", tests, failed_tests, errors);
    if (errors == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

  initial
  begin : watchdog
    int limit;
    // reset, idle checks and a fixed margin
    limit = 8 + 4 + 400;
    for (int r = 0; r < N_RUNS; r++)
      limit += run_budget(r);
    repeat (limit) @(posedge clk);
    $display("timeout: run did not finish within %0d cycles", limit);
    $display("TEST FAILED");
    $finish;
  end

endmodule

//--- bench/conv_router_properties.sv
module conv_router_properties (
  input logic                      clk,
  input logic                      reset,
  input logic                      busy,
  input conv_ctrl_pkg::seq_state_t state,
  input logic                      valid_row1_adr,
  input logic                      valid_row2_adr,
  input logic                      valid_row3_adr,
  input conv_cfg_pkg::bank_t       row1_buf_idx,
  input conv_cfg_pkg::bank_t       row2_buf_idx,
  input conv_cfg_pkg::bank_t       row3_buf_idx,
  input logic                      conv_nif_add_end,
  input logic                      conv_end
);

  ////////////////////////////////////////////////////////////
  // scan window
  ////////////////////////////////////////////////////////////

  // addresses only while scanning
  assert property (@(posedge clk) disable iff (reset)
    (state != conv_ctrl_pkg::ST_SCAN) |-> !(valid_row1_adr || valid_row2_adr || valid_row3_adr))
    else $error("row address valid outside the scan state");

  // last tile end is also a channel loop end
  assert property (@(posedge clk) disable iff (reset) conv_end |-> conv_nif_add_end)
    else $error("conv_end without conv_nif_add_end");

  ////////////////////////////////////////////////////////////
  // lanes and reset
  ////////////////////////////////////////////////////////////

  // a valid lane always names a bank
  assert property (@(posedge clk) disable iff (reset) valid_row1_adr |-> row1_buf_idx != 2'd0)
    else $error("lane 1 valid with bank 0");
  assert property (@(posedge clk) disable iff (reset) valid_row2_adr |-> row2_buf_idx != 2'd0)
    else $error("lane 2 valid with bank 0");
  assert property (@(posedge clk) disable iff (reset) valid_row3_adr |-> row3_buf_idx != 2'd0)
    else $error("lane 3 valid with bank 0");

  // idle right out of reset
  assert property (@(posedge clk) reset |=> !busy)
    else $error("busy high after reset");

endmodule

//--- logic/conv_router.sv
module conv_router #(
  parameter int PIXELS_PER_ROW = conv_cfg_pkg::PIXELS_PER_ROW
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 start,
  input  logic                 conv_out_add_end,
  input  conv_cfg_pkg::dim_t   ox,
  input  conv_cfg_pkg::dim_t   oy,
  input  conv_cfg_pkg::dim_t   ix,
  input  conv_cfg_pkg::dim_t   iy,
  input  conv_cfg_pkg::dim_t   nif,
  input  conv_cfg_pkg::small_t k,
  input  conv_cfg_pkg::small_t p,
  input  conv_cfg_pkg::small_t nif_log2,
  input  conv_cfg_pkg::small_t ix_log2,
  output logic                 busy,
  output conv_cfg_pkg::dim_t   ox_start,
  output conv_cfg_pkg::dim_t   oy_start,
  output conv_cfg_pkg::dim_t   pox,
  output conv_cfg_pkg::dim_t   poy,
  output conv_cfg_pkg::dim_t   if_idx,
  output conv_cfg_pkg::dim_t   cur_ox_start,
  output conv_cfg_pkg::dim_t   cur_oy_start,
  output conv_cfg_pkg::dim_t   cur_pox,
  output conv_cfg_pkg::dim_t   cur_poy,
  output conv_cfg_pkg::dim_t   row1_idx,
  output conv_cfg_pkg::dim_t   row2_idx,
  output conv_cfg_pkg::dim_t   row3_idx,
  output conv_cfg_pkg::bank_t  row1_buf_idx,
  output conv_cfg_pkg::bank_t  row2_buf_idx,
  output conv_cfg_pkg::bank_t  row3_buf_idx,
  output conv_cfg_pkg::dim_t   row1_buf_adr,
  output conv_cfg_pkg::dim_t   row2_buf_adr,
  output conv_cfg_pkg::dim_t   row3_buf_adr,
  output logic                 valid_row1_adr,
  output logic                 valid_row2_adr,
  output logic                 valid_row3_adr,
  output logic                 conv_pixels_add_end,
  output logic                 conv_nif_add_end,
  output logic                 conv_end
);

  // ix enters the address math only through ix_log2

  tile_if tile_bus ();

  ////////////////////////////////////////////////////////////
  // tile loop and scan
  ////////////////////////////////////////////////////////////

  tile_sequencer #(.PIXELS_PER_ROW(PIXELS_PER_ROW)) seq0 (
    .clk(clk), .reset(reset), .start(start), .conv_out_add_end(conv_out_add_end),
    .ox(ox), .oy(oy), .nif(nif), .t(tile_bus.seq),
    .busy(busy), .conv_nif_add_end(conv_nif_add_end), .conv_end(conv_end),
    .cur_ox_start(cur_ox_start), .cur_oy_start(cur_oy_start),
    .cur_pox(cur_pox), .cur_poy(cur_poy)
  );

  scan_walker #(.PIXELS_PER_ROW(PIXELS_PER_ROW)) walker0 (
    .clk(clk), .reset(reset), .k(k), .t(tile_bus.walker)
  );

  assign ox_start            = tile_bus.ox_start;
  assign oy_start            = tile_bus.oy_start;
  assign pox                 = tile_bus.pox;
  assign poy                 = tile_bus.poy;
  assign if_idx              = tile_bus.if_idx;
  assign conv_pixels_add_end = tile_bus.pass_end;

  ////////////////////////////////////////////////////////////
  // one mapper per row lane
  ////////////////////////////////////////////////////////////

  row_lane #(.LANE(0)) lane0 (
    .iy(iy), .p(p), .nif_log2(nif_log2), .ix_log2(ix_log2), .t(tile_bus.lane),
    .row_idx(row1_idx), .buf_idx(row1_buf_idx), .buf_adr(row1_buf_adr),
    .valid_adr(valid_row1_adr)
  );

  row_lane #(.LANE(1)) lane1 (
    .iy(iy), .p(p), .nif_log2(nif_log2), .ix_log2(ix_log2), .t(tile_bus.lane),
    .row_idx(row2_idx), .buf_idx(row2_buf_idx), .buf_adr(row2_buf_adr),
    .valid_adr(valid_row2_adr)
  );

  row_lane #(.LANE(2)) lane2 (
    .iy(iy), .p(p), .nif_log2(nif_log2), .ix_log2(ix_log2), .t(tile_bus.lane),
    .row_idx(row3_idx), .buf_idx(row3_buf_idx), .buf_adr(row3_buf_adr),
    .valid_adr(valid_row3_adr)
  );

endmodule

//--- logic/row_lane.sv
module row_lane #(
  parameter int LANE = 0
) (
  input  conv_cfg_pkg::dim_t   iy,
  input  conv_cfg_pkg::small_t p,
  input  conv_cfg_pkg::small_t nif_log2,
  input  conv_cfg_pkg::small_t ix_log2,
  tile_if.lane                 t,
  output conv_cfg_pkg::dim_t   row_idx,
  output conv_cfg_pkg::bank_t  buf_idx,
  output conv_cfg_pkg::dim_t   buf_adr,
  output logic                 valid_adr
);

  localparam int BANKS = conv_cfg_pkg::ROW_LANES;
  localparam int WIDE_W = 2 * conv_cfg_pkg::DIM_W;

  int                               bias0;
  int                               bias;
  int                               bank_n;
  int                               row_s;
  conv_cfg_pkg::dim_t               base_grp;
  conv_cfg_pkg::dim_t               grp;
  conv_cfg_pkg::dim_t               row_grp;
  logic [1:0]                       offset;
  logic [WIDE_W-1:0]                col_word;
  logic [conv_cfg_pkg::SMALL_W:0]   adr_shift;
  logic                             present;

  ////////////////////////////////////////////////////////////
  // row select and bank
  ////////////////////////////////////////////////////////////

  // tile row group, exact since tiles start on multiples of 3
  assign base_grp = t.oy_start / conv_cfg_pkg::dim_t'(BANKS);

  // row offset inside the group, one based
  assign bias0 = LANE + int'(t.idx_in_k) + 1 - int'(p);
  assign row_s = int'(t.oy_start) + bias0 - 1;

  always_comb
  begin
    // padding pulls the row into the group below
    if (bias0 <= 0)
    begin
      grp  = base_grp - conv_cfg_pkg::dim_t'(1);
      bias = bias0 + BANKS;
    end
    else
    begin
      grp  = base_grp;
      bias = bias0;
    end
    // compare and subtract, bias 1..12
    if (bias <= BANKS)
    begin
      bank_n = bias;
      offset = 2'd0;
    end
    else if (bias <= 2 * BANKS)
    begin
      bank_n = bias - BANKS;
      offset = 2'd1;
    end
    else if (bias <= 3 * BANKS)
    begin
      bank_n = bias - 2 * BANKS;
      offset = 2'd2;
    end
    else
    begin
      bank_n = bias - 3 * BANKS;
      offset = 2'd3;
    end
  end

  // lane exists in this tile and row is inside the map
  assign present = (LANE < int'(t.poy)) && (row_s >= 0) && (row_s < int'(iy));

  ////////////////////////////////////////////////////////////
  // address translation
  ////////////////////////////////////////////////////////////

  // row div 3
  assign row_grp = grp + conv_cfg_pkg::dim_t'(offset);

  // words per buffered row, in units of one tile width
  assign adr_shift = {1'b0, nif_log2} + {1'b0, ix_log2}
                   - (conv_cfg_pkg::SMALL_W + 1)'(conv_cfg_pkg::PIX_LOG2);

  // column offset of the tile
  assign col_word = (WIDE_W'(t.ox_start) << nif_log2) >> conv_cfg_pkg::PIX_LOG2;

  assign row_idx = present ? conv_cfg_pkg::dim_t'(row_s) : conv_cfg_pkg::NO_ROW;
  assign buf_idx = present ? conv_cfg_pkg::bank_t'(bank_n) : '0;
  assign buf_adr = present ? (row_grp << adr_shift) + conv_cfg_pkg::dim_t'(col_word)
                             + t.if_idx - conv_cfg_pkg::dim_t'(1)
                           : conv_cfg_pkg::NO_ROW;

  assign valid_adr = present && t.scan_valid;

endmodule

//--- logic/scan_walker.sv
module scan_walker #(
  parameter int PIXELS_PER_ROW = conv_cfg_pkg::PIXELS_PER_ROW
) (
  input  logic                 clk,
  input  logic                 reset,
  input  conv_cfg_pkg::small_t k,
  tile_if.walker               t
);

  // longest pass is pox + k - 1 with pox and k at their max
  localparam int PASS_MAX = PIXELS_PER_ROW + (1 << conv_cfg_pkg::SMALL_W) - 2;
  localparam int CNT_W    = $clog2(PASS_MAX + 1);

  logic [CNT_W-1:0]                 pix_cnt;
  logic [conv_cfg_pkg::SMALL_W-1:0] krow_cnt;
  conv_cfg_pkg::dim_t               pass_len;
  logic                             scanning;
  logic                             pix_last;
  logic                             krow_last;

  ////////////////////////////////////////////////////////////
  // pass and kernel ends
  ////////////////////////////////////////////////////////////

  assign scanning = t.state == conv_ctrl_pkg::ST_SCAN;

  // pixels per pass, stride one
  assign pass_len = t.pox + conv_cfg_pkg::dim_t'(k) - conv_cfg_pkg::dim_t'(1);

  assign t.pix_idx  = conv_cfg_pkg::dim_t'(pix_cnt);
  assign t.idx_in_k = conv_cfg_pkg::dim_t'(krow_cnt);

  assign pix_last  = (t.pix_idx + conv_cfg_pkg::dim_t'(1)) == pass_len;
  assign krow_last = krow_cnt == (k - conv_cfg_pkg::small_t'(1));

  // one address per scan cycle
  assign t.scan_valid = scanning;
  assign t.pass_end   = scanning && pix_last;
  // last pixel of the last kernel row
  assign t.kernel_end = t.pass_end && krow_last;

  ////////////////////////////////////////////////////////////
  // counters
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      pix_cnt  <= '0;
      krow_cnt <= '0;
    end
    else if (!scanning || t.kernel_end)
    begin
      // new channel or tile starts at pixel 0, kernel row 0
      pix_cnt  <= '0;
      krow_cnt <= '0;
    end
    else if (t.pass_end)
    begin
      pix_cnt  <= '0;
      krow_cnt <= krow_cnt + 1'b1;
    end
    else
    begin
      pix_cnt <= pix_cnt + 1'b1;
    end
  end

endmodule

//--- logic/tile_sequencer.sv
module tile_sequencer #(
  parameter int PIXELS_PER_ROW = conv_cfg_pkg::PIXELS_PER_ROW
) (
  input  logic               clk,
  input  logic               reset,
  input  logic               start,
  input  logic               conv_out_add_end,
  input  conv_cfg_pkg::dim_t ox,
  input  conv_cfg_pkg::dim_t oy,
  input  conv_cfg_pkg::dim_t nif,
  tile_if.seq                t,
  output logic               busy,
  output logic               conv_nif_add_end,
  output logic               conv_end,
  output conv_cfg_pkg::dim_t cur_ox_start,
  output conv_cfg_pkg::dim_t cur_oy_start,
  output conv_cfg_pkg::dim_t cur_pox,
  output conv_cfg_pkg::dim_t cur_poy
);

  localparam conv_cfg_pkg::dim_t TILE_W = conv_cfg_pkg::dim_t'(PIXELS_PER_ROW);
  localparam conv_cfg_pkg::dim_t TILE_H = conv_cfg_pkg::dim_t'(conv_cfg_pkg::ROW_LANES);

  // config latched at start
  conv_cfg_pkg::dim_t ox_q;
  conv_cfg_pkg::dim_t oy_q;
  conv_cfg_pkg::dim_t nif_q;

  conv_cfg_pkg::dim_t ox_left;
  conv_cfg_pkg::dim_t oy_left;
  logic               hold;
  logic               release_hold;
  logic               chan_last;
  logic               last_x;
  logic               last_y;

  ////////////////////////////////////////////////////////////
  // tile size and loop ends
  ////////////////////////////////////////////////////////////

  // columns and rows still ahead of the tile start
  assign ox_left = ox_q - t.ox_start;
  assign oy_left = oy_q - t.oy_start;

  // edge tiles get clipped
  assign t.pox = (ox_left < TILE_W) ? ox_left : TILE_W;
  assign t.poy = (oy_left < TILE_H) ? oy_left : TILE_H;

  assign last_x    = ox_left <= TILE_W;
  assign last_y    = oy_left <= TILE_H;
  assign chan_last = t.if_idx >= nif_q;

  // hold flag is the hold state itself
  assign hold         = t.state == conv_ctrl_pkg::ST_HOLD;
  assign release_hold = hold && conv_out_add_end;

  // last channel of a tile, same cycle as kernel_end
  assign conv_nif_add_end = (t.state == conv_ctrl_pkg::ST_SCAN) && t.kernel_end && chan_last;
  // last channel of the last tile
  assign conv_end = conv_nif_add_end && last_x && last_y;

  assign busy = t.state != conv_ctrl_pkg::ST_IDLE;

  ////////////////////////////////////////////////////////////
  // tile and channel loop
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      t.state    <= conv_ctrl_pkg::ST_IDLE;
      t.ox_start <= '0;
      t.oy_start <= '0;
      t.if_idx   <= conv_ctrl_pkg::FIRST_IF;
      ox_q       <= '0;
      oy_q       <= '0;
      nif_q      <= '0;
    end
    else
    begin
      case (t.state)
        conv_ctrl_pkg::ST_IDLE:
        begin
          if (start)
          begin
            ox_q       <= ox;
            oy_q       <= oy;
            nif_q      <= nif;
            t.ox_start <= '0;
            t.oy_start <= '0;
            t.if_idx   <= conv_ctrl_pkg::FIRST_IF;
            t.state    <= conv_ctrl_pkg::ST_SCAN;
          end
        end
        conv_ctrl_pkg::ST_SCAN:
        begin
          // next channel, no gap in the scan
          if (t.kernel_end && !chan_last)
          begin
            t.if_idx <= t.if_idx + conv_cfg_pkg::dim_t'(1);
          end
          else if (t.kernel_end)
          begin
            t.if_idx <= conv_ctrl_pkg::FIRST_IF;
            if (last_x && last_y)
            begin
              t.ox_start <= '0;
              t.oy_start <= '0;
              t.state    <= conv_ctrl_pkg::ST_IDLE;
            end
            else
            begin
              // ox inner, oy outer
              t.ox_start <= last_x ? '0 : t.ox_start + TILE_W;
              t.oy_start <= last_x ? t.oy_start + TILE_H : t.oy_start;
              t.state    <= conv_ctrl_pkg::ST_HOLD;
            end
          end
        end
        conv_ctrl_pkg::ST_HOLD:
        begin
          if (conv_out_add_end)
          begin
            t.state <= conv_ctrl_pkg::ST_SCAN;
          end
        end
        default:
        begin
          t.state <= conv_ctrl_pkg::ST_IDLE;
        end
      endcase
    end
  end

  // cur_* track the tile, frozen on the old tile during a hold
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      cur_ox_start <= '0;
      cur_oy_start <= '0;
      cur_pox      <= '0;
      cur_poy      <= '0;
    end
    else if (!hold || release_hold)
    begin
      cur_ox_start <= t.ox_start;
      cur_oy_start <= t.oy_start;
      cur_pox      <= t.pox;
      cur_poy      <= t.poy;
    end
  end

endmodule

//--- logic/tile_if.sv
interface tile_if;

  // current tile, from the sequencer
  conv_cfg_pkg::dim_t ox_start;
  conv_cfg_pkg::dim_t oy_start;
  conv_cfg_pkg::dim_t pox;
  conv_cfg_pkg::dim_t poy;
  conv_cfg_pkg::dim_t if_idx;
  conv_ctrl_pkg::seq_state_t state;

  // scan position, from the walker
  conv_cfg_pkg::dim_t idx_in_k;
  conv_cfg_pkg::dim_t pix_idx;
  logic scan_valid;
  logic pass_end;
  logic kernel_end;

  // tile loop, closes on kernel_end
  modport seq (
    output ox_start, oy_start, pox, poy, if_idx, state,
    input  kernel_end
  );

  // pixel and kernel-row counters
  modport walker (
    output idx_in_k, pix_idx, scan_valid, pass_end, kernel_end,
    input  state, pox, ox_start, oy_start
  );

  // row lanes only look
  modport lane (
    input ox_start, oy_start, pox, poy, if_idx, state,
    input idx_in_k, pix_idx, scan_valid, pass_end, kernel_end
  );

endinterface

//--- logic/conv_ctrl_pkg.sv
package conv_ctrl_pkg;

  ////////////////////////////////////////////////////////////
  // sequencer states
  ////////////////////////////////////////////////////////////

  // idle   waiting for start
  // scan   walking pixels, kernel rows, channels
  // hold   tile done, waiting on the output side
  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_SCAN = 2'd1,
    ST_HOLD = 2'd2
  } seq_state_t;

  ////////////////////////////////////////////////////////////
  // scan constants
  ////////////////////////////////////////////////////////////

  // channel index is one based
  localparam conv_cfg_pkg::dim_t FIRST_IF = 1;

endpackage

//--- logic/conv_cfg_pkg.sv
package conv_cfg_pkg;

  ////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////

  // dimensions, coordinates and word addresses
  localparam int DIM_W = 16;
  typedef logic [DIM_W-1:0] dim_t;

  // kernel size, padding and log2 config inputs
  localparam int SMALL_W = 4;
  typedef logic [SMALL_W-1:0] small_t;

  ////////////////////////////////////////////////////////////
  // tile geometry
  ////////////////////////////////////////////////////////////

  // output columns per tile, default for the top level
  localparam int PIXELS_PER_ROW = 32;
  // log2 of the above, used by address translation
  localparam int PIX_LOG2 = 5;

  // rows per tile, also the number of input buffer banks
  localparam int ROW_LANES = 3;

  // bank number 1..3
  // 0 is no bank
  typedef logic [1:0] bank_t;

  // marks a missing row or address
  localparam dim_t NO_ROW = '1;

endpackage
